//--- common/nco_config.svh
`ifndef NCO_CONFIG_SVH
`define NCO_CONFIG_SVH

// period word is fixed point, integer part above NCO_FRAC_W fraction bits
`define NCO_DATA_W 16
`define NCO_FRAC_W 4

// register map
`define NCO_ADDR_W      2
`define NCO_ADDR_CTRL   2'd0
`define NCO_ADDR_PERIOD 2'd1
`define NCO_ADDR_STATUS 2'd2

// maximum hop count of one sweep is 2**NCO_HOP_CNT_W - 1
`define NCO_HOP_CNT_W 8

`endif

//--- common/nco_dp_pkg.sv
`include "nco_config.svh"

package nco_dp_pkg;

  // fixed point period in system clock cycles
  typedef logic [`NCO_DATA_W-1:0] period_t;

  // integer cycle count of the modulo counter and the quantizer
  typedef logic [`NCO_DATA_W-`NCO_FRAC_W-1:0] count_t;

  // accumulator keeps the same fixed point format as the period
  typedef logic [`NCO_DATA_W-1:0] acc_t;

endpackage

//--- common/nco_reg_if.sv
`timescale 1ns/100ps
`include "nco_config.svh"

// single beat valid/ready register access, read data one cycle after transfer
interface nco_reg_if import nco_reg_pkg::*; ();

  logic                   valid;
  logic                   ready;
  logic                   we;
  reg_addr_e              addr;
  reg_word_u              wdata;
  logic [`NCO_DATA_W-1:0] rdata;
  logic                   rvalid;

  modport requester (
    output valid, we, addr, wdata,
    input  ready, rdata, rvalid
  );

  modport target (
    input  valid, we, addr, wdata,
    output ready, rdata, rvalid
  );

endinterface

//--- common/nco_reg_pkg.sv
`include "nco_config.svh"

package nco_reg_pkg;

  // register addresses as seen on the register bus
  typedef enum logic [`NCO_ADDR_W-1:0] {
    REG_CTRL   = `NCO_ADDR_CTRL,
    REG_PERIOD = `NCO_ADDR_PERIOD,
    REG_STATUS = `NCO_ADDR_STATUS
  } reg_addr_e;

  // period view, integer cycles above the fraction bits
  typedef struct packed {
    logic [`NCO_DATA_W-`NCO_FRAC_W-1:0] int_part;
    logic [`NCO_FRAC_W-1:0]             frac_part;
  } reg_period_t;

  // control view, enable sits in bit 0
  typedef struct packed {
    logic [`NCO_DATA_W-3:0] reserved;
    logic                   soft_reset;
    logic                   enable;
  } reg_ctrl_t;

  // one bus word, decoded by address as one of the two views
  typedef union packed {
    reg_period_t period;
    reg_ctrl_t   ctrl;
  } reg_word_u;

endpackage

//--- hdl/nco_hop_sequencer.sv
`timescale 1ns/100ps
`include "nco_config.svh"

module nco_hop_sequencer
  import nco_reg_pkg::*;
  import nco_dp_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      hop_start_i,
  input  logic                      hop_tick_i,
  input  period_t                   hop_start_period_i,
  input  period_t                   hop_step_i,
  input  logic [`NCO_HOP_CNT_W-1:0] hop_count_i,
  output logic                      hop_busy_o,
  nco_reg_if.requester              bus_o
);

  period_t                   period_q;
  period_t                   step_q;
  logic [`NCO_HOP_CNT_W-1:0] left_q;
  // ticks seen but not yet turned into an accepted write
  logic [`NCO_HOP_CNT_W-1:0] pend_q;
  logic                      tick;
  logic                      accept;

  assign hop_busy_o = (left_q != '0);
  assign tick       = hop_tick_i & hop_busy_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write request, held until the arbiter grants it
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign bus_o.valid = hop_busy_o & (pend_q != '0);
  assign bus_o.we    = 1'b1;
  assign bus_o.addr  = REG_PERIOD;
  assign bus_o.wdata = period_q;
  assign accept      = bus_o.valid & bus_o.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      left_q <= '0;
      pend_q <= '0;
    end else if (hop_start_i) begin
      left_q <= hop_count_i;
      pend_q <= '0;
    end else begin
      if (accept) begin
        left_q <= left_q - 1'b1;
      end
      case ({tick, accept})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
    end
  end

  // next hop value is the previous one plus the step
  always_ff @(posedge clk_i) begin
    if (hop_start_i) begin
      period_q <= hop_start_period_i;
      step_q   <= hop_step_i;
    end else if (accept) begin
      period_q <= period_q + step_q;
    end
  end

endmodule

//--- hdl/nco_reg_arbiter.sv
`timescale 1ns/100ps

module nco_reg_arbiter (
  input  logic       clk_i,
  input  logic       arst_n_i,
  nco_reg_if.target    req_a_i,
  nco_reg_if.target    req_b_i,
  nco_reg_if.requester tgt_o
);

  logic grant_a;
  logic grant_b;
  // set when requester A won the last contested transfer
  logic last_a_q;
  // set when the outstanding read belongs to requester B
  logic rd_b_q;
  logic xfer;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // grant and request mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (req_a_i.valid && req_b_i.valid) begin
      grant_a = ~last_a_q;
      grant_b = last_a_q;
    end else begin
      grant_a = req_a_i.valid;
      grant_b = req_b_i.valid;
    end
  end

  assign tgt_o.valid = grant_a | grant_b;
  assign tgt_o.we    = grant_b ? req_b_i.we    : req_a_i.we;
  assign tgt_o.addr  = grant_b ? req_b_i.addr  : req_a_i.addr;
  assign tgt_o.wdata = grant_b ? req_b_i.wdata : req_a_i.wdata;

  // the loser sees ready low and keeps waiting
  assign req_a_i.ready = grant_a & tgt_o.ready;
  assign req_b_i.ready = grant_b & tgt_o.ready;

  assign xfer = tgt_o.valid & tgt_o.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_a_q <= 1'b0;
      rd_b_q   <= 1'b0;
    end else begin
      if (xfer && req_a_i.valid && req_b_i.valid) begin
        last_a_q <= ~last_a_q;
      end
      if (xfer && !tgt_o.we) begin
        rd_b_q <= grant_b;
      end
    end
  end

  // read response goes back to whoever issued the read
  assign req_a_i.rdata  = tgt_o.rdata;
  assign req_b_i.rdata  = tgt_o.rdata;
  assign req_a_i.rvalid = tgt_o.rvalid & ~rd_b_q;
  assign req_b_i.rvalid = tgt_o.rvalid & rd_b_q;

endmodule

//--- hdl/nco_subsys.sv
`timescale 1ns/100ps
`include "nco_config.svh"

module nco_subsys
  import nco_reg_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      host_valid_i,
  input  logic                      host_we_i,
  input  logic [`NCO_ADDR_W-1:0]    host_addr_i,
  input  logic [`NCO_DATA_W-1:0]    host_wdata_i,
  output logic                      host_ready_o,
  output logic [`NCO_DATA_W-1:0]    host_rdata_o,
  output logic                      host_rvalid_o,
  input  logic                      hop_start_i,
  input  logic                      hop_tick_i,
  input  logic [`NCO_DATA_W-1:0]    hop_start_period_i,
  input  logic [`NCO_DATA_W-1:0]    hop_step_i,
  input  logic [`NCO_HOP_CNT_W-1:0] hop_count_i,
  output logic                      hop_busy_o,
  output logic                      clk_o
);

  nco_reg_if host_bus ();
  nco_reg_if seq_bus ();
  nco_reg_if core_bus ();

  // host port is requester A
  assign host_bus.valid = host_valid_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = reg_addr_e'(host_addr_i);
  assign host_bus.wdata = reg_word_u'(host_wdata_i);
  assign host_ready_o   = host_bus.ready;
  assign host_rdata_o   = host_bus.rdata;
  assign host_rvalid_o  = host_bus.rvalid;

  nco_hop_sequencer u_seq (
    .clk_i, .arst_n_i, .hop_start_i, .hop_tick_i, .hop_start_period_i,
    .hop_step_i, .hop_count_i, .hop_busy_o,
    .bus_o (seq_bus.requester)
  );

  nco_reg_arbiter u_arb (
    .clk_i, .arst_n_i,
    .req_a_i (host_bus.target),
    .req_b_i (seq_bus.target),
    .tgt_o   (core_bus.requester)
  );

  nco_core u_core (
    .clk_i, .arst_n_i,
    .bus_i (core_bus.target),
    .clk_o
  );

endmodule

//--- nco/nco_core.sv
`timescale 1ns/100ps
`include "nco_config.svh"

module nco_core
  import nco_reg_pkg::*;
  import nco_dp_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  nco_reg_if.target bus_i,
  output logic      clk_o
);

  logic                   enable_q;
  logic                   soft_reset_q;
  period_t                period_q;
  acc_t                   acc_q;
  count_t                 cnt_q;
  count_t                 acc_int;
  logic [`NCO_FRAC_W-1:0] acc_frac;
  count_t                 quant;
  acc_t                   diff;
  logic                   wrap;
  logic                   clk_int;
  logic                   wr_ctrl;
  logic                   wr_period;
  logic                   running;
  reg_word_u              ctrl_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register file
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign bus_i.ready = 1'b1;
  assign wr_ctrl     = bus_i.valid & bus_i.we & (bus_i.addr == REG_CTRL);
  assign wr_period   = bus_i.valid & bus_i.we & (bus_i.addr == REG_PERIOD);
  assign running     = enable_q & ~soft_reset_q & (period_q != '0);

  always_comb begin
    ctrl_word                 = '0;
    ctrl_word.ctrl.soft_reset = soft_reset_q;
    ctrl_word.ctrl.enable     = enable_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q     <= 1'b0;
      soft_reset_q <= 1'b0;
      bus_i.rvalid <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        enable_q     <= bus_i.wdata.ctrl.enable;
        soft_reset_q <= bus_i.wdata.ctrl.soft_reset;
      end
      bus_i.rvalid <= bus_i.valid & ~bus_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    case (bus_i.addr)
      REG_CTRL:   bus_i.rdata <= ctrl_word;
      REG_PERIOD: bus_i.rdata <= period_q;
      REG_STATUS: bus_i.rdata <= {{(`NCO_DATA_W-2){1'b0}}, running, enable_q};
      default:    bus_i.rdata <= '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // quantizer and error feedback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign acc_int  = acc_q[`NCO_DATA_W-1:`NCO_FRAC_W];
  assign acc_frac = acc_q[`NCO_FRAC_W-1:0];

  // exact half rounds towards the even integer
  always_comb begin
    if (acc_frac == {1'b1, {(`NCO_FRAC_W-1){1'b0}}}) begin
      quant = acc_int + acc_int[0];
    end else if (acc_frac[`NCO_FRAC_W-1]) begin
      quant = acc_int + 1'b1;
    end else begin
      quant = acc_int;
    end
  end

  // error left by this output period is carried into the next one
  assign diff    = period_q - {quant, {`NCO_FRAC_W{1'b0}}};
  assign wrap    = ({1'b0, cnt_q} + 1'b1) >= {1'b0, quant};
  assign clk_int = cnt_q > (quant >> 1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      period_q <= '0;
      acc_q    <= '0;
      cnt_q    <= '0;
      clk_o    <= 1'b0;
    end else if (soft_reset_q) begin
      period_q <= '0;
      acc_q    <= '0;
      clk_o    <= 1'b0;
    end else if (wr_period) begin
      period_q <= bus_i.wdata.period;
      acc_q    <= bus_i.wdata.period;
      cnt_q    <= '0;
    end else if (enable_q) begin
      clk_o <= clk_int;
      if (wrap) begin
        cnt_q <= '0;
        acc_q <= acc_q + diff;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- nco_subsys.f
+incdir+common
common/nco_reg_pkg.sv
common/nco_dp_pkg.sv
common/nco_reg_if.sv
hdl/nco_reg_arbiter.sv
hdl/nco_hop_sequencer.sv
nco/nco_core.sv
hdl/nco_subsys.sv
tests/nco_subsys_asserts.sv
tests/nco_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f nco_subsys.f \
  --top-module nco_subsys_tb -Mdir obj_dir -o nco_sim \
  && ./obj_dir/nco_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- tests/nco_subsys_asserts.sv
`timescale 1ns/100ps
`include "nco_config.svh"

module nco_subsys_asserts (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   grant_a_i,
  input logic                   grant_b_i,
  input logic                   a_valid_i,
  input logic                   a_ready_i,
  input logic [`NCO_ADDR_W+`NCO_DATA_W:0] a_fields_i,
  input logic                   b_valid_i,
  input logic                   b_ready_i,
  input logic [`NCO_ADDR_W+`NCO_DATA_W:0] b_fields_i,
  input logic                   tgt_valid_i,
  input logic                   tgt_ready_i,
  input logic                   tgt_we_i,
  input logic                   tgt_rvalid_i
);

  // at most one requester is granted in any cycle
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({grant_a_i, grant_b_i}))
    else $error("arbiter granted both requesters");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a waiting requester holds its request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    a_valid_i && !a_ready_i |=> a_valid_i && $stable(a_fields_i))
    else $error("requester A changed its request while waiting");

  a_hold_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_fields_i))
    else $error("requester B changed its request while waiting");

  // read data returns exactly one cycle after the read transfer
  a_rvalid_after: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tgt_valid_i && tgt_ready_i && !tgt_we_i |=> tgt_rvalid_i)
    else $error("read transfer without rvalid one cycle later");

  a_rvalid_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tgt_rvalid_i |-> $past(tgt_valid_i && tgt_ready_i && !tgt_we_i))
    else $error("rvalid without a read transfer one cycle before");

endmodule

bind nco_reg_arbiter nco_subsys_asserts u_asserts (
  .clk_i, .arst_n_i,
  .grant_a_i    (grant_a),
  .grant_b_i    (grant_b),
  .a_valid_i    (req_a_i.valid),
  .a_ready_i    (req_a_i.ready),
  .a_fields_i   ({req_a_i.we, req_a_i.addr, req_a_i.wdata}),
  .b_valid_i    (req_b_i.valid),
  .b_ready_i    (req_b_i.ready),
  .b_fields_i   ({req_b_i.we, req_b_i.addr, req_b_i.wdata}),
  .tgt_valid_i  (tgt_o.valid),
  .tgt_ready_i  (tgt_o.ready),
  .tgt_we_i     (tgt_o.we),
  .tgt_rvalid_i (tgt_o.rvalid)
);

//--- tests/nco_subsys_tb.sv
`timescale 1ns/100ps
`include "nco_config.svh"

module nco_subsys_tb;

  // reset, register, integer, fractional and sweep tests with a margin of two
  localparam int RUN_CYCLES = 2 * (20 + 60 + 5 * 20 * 24 + 3 * 70 * 22 + 12 * 8 + 80);

  logic clk_i = 1'b0;
  logic arst_n_i, host_valid_i, host_we_i, host_ready_o, host_rvalid_o;
  logic [`NCO_ADDR_W-1:0] host_addr_i;
  logic [`NCO_DATA_W-1:0] host_wdata_i, host_rdata_o, hop_start_period_i, hop_step_i;
  logic hop_start_i, hop_tick_i, hop_busy_o, clk_o;
  logic [`NCO_HOP_CNT_W-1:0] hop_count_i;

  logic chk_reset, chk_rd, chk_int, chk_soft, chk_frac, sum_chk, chk_sweep, cnt_chk;
  logic sweep_end, host_xfer_q, clk_d, edge_pulse;
  logic [`NCO_DATA_W-1:0] exp_rdata, sw_start, sw_step, sw_last, per_fx;
  int sw_count, exp_gap, exp_fx, err_cnt, err_mark, test_cnt, seed;
  int cycle_cnt, last_edge, edge_gap, edge_num, frac_sum, frac_cnt, sum_err;
  int rd_issued, rd_returned, inc_cnt;

  nco_subsys DUT (.*);

  always #2 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor for output clock edges and host reads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk_i) begin
    cycle_cnt   <= cycle_cnt + 1;
    clk_d       <= clk_o;
    host_xfer_q <= host_valid_i && host_ready_o;
    edge_pulse  <= 1'b0;
    if (clk_o && !clk_d) begin
      edge_gap   <= cycle_cnt - last_edge;
      last_edge  <= cycle_cnt;
      edge_num   <= edge_num + 1;
      edge_pulse <= 1'b1;
    end
    if (!chk_frac) begin
      frac_sum <= 0;
      frac_cnt <= 0;
    end else if (edge_pulse && frac_cnt < 64) begin
      frac_sum <= frac_sum + edge_gap;
      frac_cnt <= frac_cnt + 1;
    end
    if (!chk_sweep) begin
      rd_issued   <= 0;
      rd_returned <= 0;
      inc_cnt     <= 0;
      sw_last     <= sw_start - sw_step;
    end else begin
      if (host_valid_i && host_ready_o && !host_we_i) rd_issued <= rd_issued + 1;
      if (host_rvalid_o) begin
        rd_returned <= rd_returned + 1;
        // the reference only moves on by one step per observed hop
        if (host_rdata_o == sw_last + sw_step) begin
          inc_cnt <= inc_cnt + 1;
          sw_last <= sw_last + sw_step;
        end
      end
    end
  end

  // 64 spacings compared with 64 periods, both in 1/16 cycle units
  assign sum_err = frac_sum * 16 - 64 * exp_fx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_reset: assert property (@(posedge clk_i)
    chk_reset |-> !clk_o && !host_ready_o && !host_rvalid_o && !hop_busy_o)
    else begin
      err_cnt++;
      $display("[ERROR] clk_o/host_ready_o/host_rvalid_o/hop_busy_o got %h exp 0",
        {$sampled(clk_o), $sampled(host_ready_o), $sampled(host_rvalid_o),
         $sampled(hop_busy_o)});
    end
  a_rd_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rvalid_o && chk_rd |-> host_rdata_o == exp_rdata)
    else begin
      err_cnt++;
      $display("[ERROR] host_rdata_o got %h exp %h", $sampled(host_rdata_o), exp_rdata);
    end
  a_rd_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_valid_i && host_ready_o && !host_we_i && chk_rd |=> host_rvalid_o)
    else begin
      err_cnt++;
      $display("read data did not return one cycle after the host read");
    end
  a_int: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    edge_pulse && chk_int |-> edge_gap == exp_gap)
    else begin
      err_cnt++;
      $display("[ERROR] clk_o spacing got %h exp %h", $sampled(edge_gap), exp_gap);
    end
  a_soft: assert property (@(posedge clk_i) disable iff (!arst_n_i) chk_soft |-> !clk_o)
    else begin
      err_cnt++;
      $display("[ERROR] clk_o got %h exp 0 under soft reset", $sampled(clk_o));
    end
  a_frac: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    edge_pulse && chk_frac |-> edge_gap == exp_gap || edge_gap == exp_gap + 1)
    else begin
      err_cnt++;
      $display("[ERROR] clk_o spacing got %h exp %h or %h", $sampled(edge_gap), exp_gap,
        exp_gap + 1);
    end
  a_sum: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sum_chk |-> sum_err <= 16 && sum_err >= -16)
    else begin
      err_cnt++;
      $display("[ERROR] clk_o 64 spacings x16 got %h exp %h", frac_sum * 16, 64 * exp_fx);
    end
  a_sweep: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rvalid_o && chk_sweep |-> host_rdata_o == sw_last || host_rdata_o == sw_last + sw_step)
    else begin
      err_cnt++;
      $display("[ERROR] host_rdata_o got %h exp %h or %h", $sampled(host_rdata_o), sw_last,
        sw_last + sw_step);
    end
  a_counts: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_chk |-> rd_issued == rd_returned && inc_cnt == sw_count)
    else begin
      err_cnt++;
      $display("[ERROR] reads returned got %h exp %h, hops got %h exp %h", rd_returned,
        rd_issued, inc_cnt, sw_count);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers, inputs change 1 ns after the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic host_write(input logic [`NCO_ADDR_W-1:0] addr, input logic [15:0] data);
    host_valid_i = 1'b1;
    host_we_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    do step_cycle(); while (!host_xfer_q);
    host_valid_i = 1'b0;
    host_we_i    = 1'b0;
  endtask

  task automatic host_read(input logic [`NCO_ADDR_W-1:0] addr, input logic [15:0] exp);
    exp_rdata    = exp;
    chk_rd       = 1'b1;
    host_valid_i = 1'b1;
    host_we_i    = 1'b0;
    host_addr_i  = addr;
    do step_cycle(); while (!host_xfer_q);
    host_valid_i = 1'b0;
    step_cycle();
    chk_rd = 1'b0;
  endtask

  task automatic wait_edges(input int n);
    int target;
    target = edge_num + n;
    while (edge_num < target) step_cycle();
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %s finished, %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    repeat (RUN_CYCLES) @(posedge clk_i);
    $display("timeout, the tests did not finish within %0d cycles", RUN_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin
    seed = $urandom(22423);
    {arst_n_i, host_valid_i, host_we_i, host_addr_i, host_wdata_i} = '0;
    {hop_start_i, hop_tick_i, hop_start_period_i, hop_step_i, hop_count_i} = '0;
    {chk_reset, chk_rd, chk_int, chk_soft, chk_frac, sum_chk, chk_sweep, cnt_chk} = '0;
    {sweep_end, sw_start, sw_step, exp_rdata} = '0;
    {cycle_cnt, last_edge, edge_num, err_cnt, err_mark, test_cnt, sw_count} = '0;
    {exp_gap, exp_fx} = '0;
    repeat (2) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    chk_reset = 1'b1;
    repeat (3) step_cycle();
    chk_reset = 1'b0;
    host_read(`NCO_ADDR_STATUS, 16'h0000);
    finish_test("reset");

    per_fx = 16'($urandom);
    host_write(`NCO_ADDR_PERIOD, per_fx);
    host_read(`NCO_ADDR_PERIOD, per_fx);
    host_write(`NCO_ADDR_CTRL, 16'h0001);
    host_read(`NCO_ADDR_CTRL, 16'h0001);
    finish_test("register access");

    repeat (5) begin
      exp_gap = $urandom_range(4, 20);
      host_write(`NCO_ADDR_PERIOD, 16'(exp_gap << `NCO_FRAC_W));
      wait_edges(2);
      chk_int = 1'b1;
      wait_edges(16);
      chk_int = 1'b0;
    end
    // soft reset with enable still set
    host_write(`NCO_ADDR_CTRL, 16'h0003);
    repeat (2) step_cycle();
    chk_soft = 1'b1;
    repeat (4) step_cycle();
    chk_soft = 1'b0;
    host_write(`NCO_ADDR_CTRL, 16'h0001);
    finish_test("integer period");

    repeat (3) begin
      per_fx  = {12'($urandom_range(4, 20)), 4'($urandom_range(1, 15))};
      exp_fx  = per_fx;
      exp_gap = per_fx >> `NCO_FRAC_W;
      host_write(`NCO_ADDR_PERIOD, per_fx);
      wait_edges(2);
      chk_frac = 1'b1;
      while (frac_cnt < 64) step_cycle();
      sum_chk = 1'b1;
      step_cycle();
      sum_chk  = 1'b0;
      chk_frac = 1'b0;
    end
    finish_test("fractional period");

    sw_start = 16'($urandom_range(64, 400));
    sw_step  = 16'($urandom_range(1, 40));
    sw_count = $urandom_range(4, 10);
    host_write(`NCO_ADDR_PERIOD, sw_start - sw_step);
    step_cycle();
    chk_sweep          = 1'b1;
    hop_start_period_i = sw_start;
    hop_step_i         = sw_step;
    hop_count_i        = 8'(sw_count);
    hop_start_i        = 1'b1;
    step_cycle();
    hop_start_i = 1'b0;
    fork
      begin
        repeat (sw_count) begin
          repeat ($urandom_range(1, 6)) step_cycle();
          hop_tick_i = 1'b1;
          step_cycle();
          hop_tick_i = 1'b0;
        end
        while (hop_busy_o) step_cycle();
        repeat (3) step_cycle();
        sweep_end = 1'b1;
      end
      begin
        host_valid_i = 1'b1;
        host_we_i    = 1'b0;
        host_addr_i  = `NCO_ADDR_PERIOD;
        do step_cycle(); while (!(host_xfer_q && sweep_end));
        host_valid_i = 1'b0;
      end
    join
    repeat (2) step_cycle();
    cnt_chk = 1'b1;
    step_cycle();
    cnt_chk   = 1'b0;
    chk_sweep = 1'b0;
    host_read(`NCO_ADDR_PERIOD, sw_start + 16'(sw_count - 1) * sw_step);
    finish_test("sweep and arbitration");

    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
